/* source/backend_macros.svh */
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

// data path width
`define BACKEND_XLEN 32

// register address width
`define BACKEND_REG_AW 5

// architectural register count
`define BACKEND_NREGS 32

`endif

/* source/isa_pkg.sv */
`default_nettype none

`include "backend_macros.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SLT  = 6'h06,
        OP_ADDI = 6'h08,
        OP_DIVU = 6'h10,
        OP_MODU = 6'h11
    } opcode_e;

    // field positions in the raw instruction word
    localparam int OPCODE_LSB = 26;
    localparam int OPCODE_MSB = 31;
    localparam int RD_LSB = 0;
    localparam int RD_MSB = RD_LSB + `BACKEND_REG_AW - 1;
    localparam int RJ_LSB = RD_MSB + 1;
    localparam int RJ_MSB = RJ_LSB + `BACKEND_REG_AW - 1;
    localparam int RK_LSB = RJ_MSB + 1;
    localparam int RK_MSB = RK_LSB + `BACKEND_REG_AW - 1;
    localparam int IMM_LSB = 10;
    localparam int IMM_MSB = 21;
    localparam int IMM_W = IMM_MSB - IMM_LSB + 1;

endpackage

`default_nettype wire

/* source/pipeline_pkg.sv */
`default_nettype none

`include "backend_macros.svh"

package pipeline_pkg;

    typedef enum logic [3:0] {
        EXEC_ADD  = 4'd0,
        EXEC_SUB  = 4'd1,
        EXEC_AND  = 4'd2,
        EXEC_OR   = 4'd3,
        EXEC_XOR  = 4'd4,
        EXEC_SLT  = 4'd5,
        EXEC_DIVU = 4'd6,
        EXEC_MODU = 4'd7,
        EXEC_NOP  = 4'd15
    } exec_op_e;

    typedef struct packed {
        logic [`BACKEND_XLEN-1:0]   pc;
        exec_op_e                   op;
        logic [`BACKEND_REG_AW-1:0] rj;
        logic [`BACKEND_REG_AW-1:0] rk;
        logic                       use_imm;
        logic [`BACKEND_XLEN-1:0]   imm;
        logic [`BACKEND_REG_AW-1:0] rd;
        logic                       reg_write_en;
    } id_dispatch_t;

    typedef struct packed {
        logic [`BACKEND_XLEN-1:0]   pc;
        exec_op_e                   op;
        logic [`BACKEND_XLEN-1:0]   operand_a;
        logic [`BACKEND_XLEN-1:0]   operand_b;
        logic [`BACKEND_REG_AW-1:0] rd;
        logic                       reg_write_en;
    } dispatch_ex_t;

    // write-back bundle, also used for forwarding
    typedef struct packed {
        logic                       reg_write_en;
        logic [`BACKEND_REG_AW-1:0] reg_write_addr;
        logic [`BACKEND_XLEN-1:0]   reg_write_data;
    } push_forward_t;

endpackage

`default_nettype wire

/* source/backend_intf.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

interface regfile_read_if;
    logic [`BACKEND_REG_AW-1:0] rj_addr;
    logic [`BACKEND_REG_AW-1:0] rk_addr;
    logic [`BACKEND_XLEN-1:0]   rj_data;
    logic [`BACKEND_XLEN-1:0]   rk_data;

    modport reader (output rj_addr, output rk_addr, input rj_data, input rk_data);

    // data comes back in the same cycle
    modport provider (input rj_addr, input rk_addr, output rj_data, output rk_data);
endinterface

interface div_if;
    logic                     req_valid;
    logic                     req_ready;
    logic [`BACKEND_XLEN-1:0] dividend;
    logic [`BACKEND_XLEN-1:0] divisor;
    logic                     is_mod;
    logic                     resp_valid;
    logic [`BACKEND_XLEN-1:0] result;

    modport client (
        output req_valid, dividend, divisor, is_mod,
        input  req_ready, resp_valid, result
    );

    modport server (
        input  req_valid, dividend, divisor, is_mod,
        output req_ready, resp_valid, result
    );
endinterface

`default_nettype wire

/* source/decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

module decoder (
    input  logic [`BACKEND_XLEN-1:0]    inst_i,
    input  logic [`BACKEND_XLEN-1:0]    pc_i,
    output pipeline_pkg::id_dispatch_t  decoded_o
);

    isa_pkg::opcode_e         opcode;
    logic [isa_pkg::IMM_W-1:0] imm12;
    logic                     known;

    assign opcode = isa_pkg::opcode_e'(inst_i[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);
    assign imm12 = inst_i[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];

    always_comb begin
        known = 1'b1;
        decoded_o.pc = pc_i;
        decoded_o.rd = inst_i[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
        decoded_o.rj = inst_i[isa_pkg::RJ_MSB:isa_pkg::RJ_LSB];
        decoded_o.rk = inst_i[isa_pkg::RK_MSB:isa_pkg::RK_LSB];
        decoded_o.imm = {{(`BACKEND_XLEN - isa_pkg::IMM_W){imm12[isa_pkg::IMM_W-1]}}, imm12};
        decoded_o.use_imm = 1'b0;
        case (opcode)
            isa_pkg::OP_ADD:  decoded_o.op = pipeline_pkg::EXEC_ADD;
            isa_pkg::OP_SUB:  decoded_o.op = pipeline_pkg::EXEC_SUB;
            isa_pkg::OP_AND:  decoded_o.op = pipeline_pkg::EXEC_AND;
            isa_pkg::OP_OR:   decoded_o.op = pipeline_pkg::EXEC_OR;
            isa_pkg::OP_XOR:  decoded_o.op = pipeline_pkg::EXEC_XOR;
            isa_pkg::OP_SLT:  decoded_o.op = pipeline_pkg::EXEC_SLT;
            isa_pkg::OP_DIVU: decoded_o.op = pipeline_pkg::EXEC_DIVU;
            isa_pkg::OP_MODU: decoded_o.op = pipeline_pkg::EXEC_MODU;
            isa_pkg::OP_ADDI: begin
                decoded_o.op = pipeline_pkg::EXEC_ADD;
                decoded_o.use_imm = 1'b1;
            end
            default: begin
                decoded_o.op = pipeline_pkg::EXEC_NOP;
                known = 1'b0;
            end
        endcase
        // r0 is never written
        decoded_o.reg_write_en = known && (decoded_o.rd != '0);
    end

endmodule

`default_nettype wire

/* source/pipe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the held item leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign out_data_o = data_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready_o && in_valid_i) begin
            data_q <= in_data_i;
        end
    end

endmodule

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

module regfile (
    input  logic                        clk,
    input  logic                        reset_i,

    input  pipeline_pkg::push_forward_t write_i,

    regfile_read_if.provider            rd_port
);

    logic [`BACKEND_XLEN-1:0] regs [`BACKEND_NREGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BACKEND_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_i.reg_write_en && (write_i.reg_write_addr != '0)) begin
            regs[write_i.reg_write_addr] <= write_i.reg_write_data;
        end
    end

    // r0 reads as zero
    assign rd_port.rj_data = (rd_port.rj_addr == '0) ? '0 : regs[rd_port.rj_addr];
    assign rd_port.rk_data = (rd_port.rk_addr == '0) ? '0 : regs[rd_port.rk_addr];

endmodule

`default_nettype wire

/* source/dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

module dispatch (
    input  pipeline_pkg::id_dispatch_t  id_i,

    input  pipeline_pkg::push_forward_t ex_forward_i,
    input  pipeline_pkg::push_forward_t wb_forward_i,

    regfile_read_if.reader              rf_port,

    output pipeline_pkg::dispatch_ex_t  ex_o
);

    logic [`BACKEND_XLEN-1:0] rj_value;
    logic [`BACKEND_XLEN-1:0] rk_value;

    // newest producer wins: ex, then wb, then the register file
    function automatic logic [`BACKEND_XLEN-1:0] pick_operand(
        input logic [`BACKEND_REG_AW-1:0] addr,
        input logic [`BACKEND_XLEN-1:0]   rf_data,
        input pipeline_pkg::push_forward_t ex_fwd,
        input pipeline_pkg::push_forward_t wb_fwd
    );
        if (addr == '0) begin
            return '0;
        end else if (ex_fwd.reg_write_en && ex_fwd.reg_write_addr == addr) begin
            return ex_fwd.reg_write_data;
        end else if (wb_fwd.reg_write_en && wb_fwd.reg_write_addr == addr) begin
            return wb_fwd.reg_write_data;
        end
        return rf_data;
    endfunction

    assign rf_port.rj_addr = id_i.rj;
    assign rf_port.rk_addr = id_i.rk;

    assign rj_value = pick_operand(id_i.rj, rf_port.rj_data, ex_forward_i, wb_forward_i);
    assign rk_value = pick_operand(id_i.rk, rf_port.rk_data, ex_forward_i, wb_forward_i);

    always_comb begin
        ex_o.pc = id_i.pc;
        ex_o.op = id_i.op;
        ex_o.operand_a = rj_value;
        ex_o.operand_b = id_i.use_imm ? id_i.imm : rk_value;
        ex_o.rd = id_i.rd;
        ex_o.reg_write_en = id_i.reg_write_en;
    end

endmodule

`default_nettype wire

/* source/ex.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

module ex (
    input  logic                        clk,
    input  logic                        reset_i,

    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  pipeline_pkg::dispatch_ex_t  in_data_i,

    div_if.client                       div_port,

    output pipeline_pkg::push_forward_t ex_forward_o,
    output pipeline_pkg::push_forward_t wb_o,

    output logic                        commit_valid_o,
    output logic [`BACKEND_XLEN-1:0]    commit_pc_o
);

    logic                        is_div;
    logic                        fire;
    logic                        div_busy_q;
    logic [`BACKEND_XLEN-1:0]    result;
    logic                        commit_valid_q;
    logic [`BACKEND_XLEN-1:0]    commit_pc_q;
    pipeline_pkg::push_forward_t wb_q;

    assign is_div = (in_data_i.op == pipeline_pkg::EXEC_DIVU)
                 || (in_data_i.op == pipeline_pkg::EXEC_MODU);

    // a division holds the stage until the divider answers
    assign in_ready_o = !(in_valid_i && is_div) || div_port.resp_valid;
    assign fire = in_valid_i && in_ready_o;

    // one request per division
    assign div_port.req_valid = in_valid_i && is_div && !div_busy_q;
    assign div_port.dividend = in_data_i.operand_a;
    assign div_port.divisor = in_data_i.operand_b;
    assign div_port.is_mod = (in_data_i.op == pipeline_pkg::EXEC_MODU);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_busy_q <= 1'b0;
        end else if (div_port.resp_valid) begin
            div_busy_q <= 1'b0;
        end else if (div_port.req_valid && div_port.req_ready) begin
            div_busy_q <= 1'b1;
        end
    end

    always_comb begin
        case (in_data_i.op)
            pipeline_pkg::EXEC_ADD:  result = in_data_i.operand_a + in_data_i.operand_b;
            pipeline_pkg::EXEC_SUB:  result = in_data_i.operand_a - in_data_i.operand_b;
            pipeline_pkg::EXEC_AND:  result = in_data_i.operand_a & in_data_i.operand_b;
            pipeline_pkg::EXEC_OR:   result = in_data_i.operand_a | in_data_i.operand_b;
            pipeline_pkg::EXEC_XOR:  result = in_data_i.operand_a ^ in_data_i.operand_b;
            pipeline_pkg::EXEC_SLT: begin
                result = '0;
                result[0] = $signed(in_data_i.operand_a) < $signed(in_data_i.operand_b);
            end
            pipeline_pkg::EXEC_DIVU: result = div_port.result;
            pipeline_pkg::EXEC_MODU: result = div_port.result;
            default:                 result = '0;
        endcase
    end

    always_comb begin
        ex_forward_o.reg_write_en = fire && in_data_i.reg_write_en;
        ex_forward_o.reg_write_addr = in_data_i.rd;
        ex_forward_o.reg_write_data = result;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= fire;
        end
    end

    // result register
    always_ff @(posedge clk) begin
        if (fire) begin
            commit_pc_q <= in_data_i.pc;
            wb_q.reg_write_en <= in_data_i.reg_write_en;
            wb_q.reg_write_addr <= in_data_i.rd;
            wb_q.reg_write_data <= result;
        end
    end

    always_comb begin
        wb_o = wb_q;
        wb_o.reg_write_en = commit_valid_q && wb_q.reg_write_en;
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_pc_o = commit_pc_q;

endmodule

`default_nettype wire

/* source/div.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

module div (
    input  logic  clk,
    input  logic  reset_i,

    div_if.server div_port
);

    localparam int CNT_W = $clog2(`BACKEND_XLEN);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`BACKEND_XLEN - 1);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } state_e;

    state_e                   state_q;
    logic [CNT_W-1:0]         count_q;
    logic [`BACKEND_XLEN-1:0] quot_q;
    logic [`BACKEND_XLEN-1:0] rem_q;
    logic [`BACKEND_XLEN-1:0] divisor_q;
    logic                     is_mod_q;
    logic [`BACKEND_XLEN:0]   rem_shift;
    logic [`BACKEND_XLEN:0]   diff;
    logic                     fits;

    assign rem_shift = {rem_q, quot_q[`BACKEND_XLEN-1]};
    assign diff = rem_shift - {1'b0, divisor_q};
    // divisor 0 always fits: quotient all ones, remainder is the dividend
    assign fits = rem_shift >= {1'b0, divisor_q};

    assign div_port.req_ready = (state_q == DIV_IDLE);
    assign div_port.resp_valid = (state_q == DIV_DONE);
    assign div_port.result = is_mod_q ? rem_q : quot_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (div_port.req_valid) begin
                        state_q <= DIV_RUN;
                        count_q <= '0;
                    end
                end
                DIV_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == LAST_STEP) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // one quotient bit per cycle
    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && div_port.req_valid) begin
            quot_q <= div_port.dividend;
            rem_q <= '0;
            divisor_q <= div_port.divisor;
            is_mod_q <= div_port.is_mod;
        end else if (state_q == DIV_RUN) begin
            quot_q <= {quot_q[`BACKEND_XLEN-2:0], fits};
            rem_q <= fits ? diff[`BACKEND_XLEN-1:0] : rem_shift[`BACKEND_XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

/* source/backend.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

module backend (
    input  logic                       clk,
    input  logic                       reset_i,

    input  logic                       inst_valid_i,
    output logic                       inst_ready_o,
    input  logic [`BACKEND_XLEN-1:0]   inst_i,
    input  logic [`BACKEND_XLEN-1:0]   pc_i,

    output logic                       commit_valid_o,
    output logic [`BACKEND_XLEN-1:0]   commit_pc_o,
    output logic [`BACKEND_REG_AW-1:0] commit_rd_o,
    output logic                       commit_we_o,
    output logic [`BACKEND_XLEN-1:0]   commit_data_o
);

    regfile_read_if rf_bus ();
    div_if          div_bus ();

    // decode
    pipeline_pkg::id_dispatch_t  decoded;
    pipeline_pkg::id_dispatch_t  id_q;
    logic                        id_valid;
    logic                        dispatch_ready;

    // dispatch
    pipeline_pkg::dispatch_ex_t  dispatched;
    pipeline_pkg::dispatch_ex_t  ex_q;
    logic                        ex_valid;
    logic                        ex_ready;

    // execute
    pipeline_pkg::push_forward_t ex_forward;
    pipeline_pkg::push_forward_t wb_forward;

    decoder u_decoder (
        .inst_i(inst_i),
        .pc_i(pc_i),
        .decoded_o(decoded)
    );

    pipe_stage #(
        .payload_t(pipeline_pkg::id_dispatch_t)
    ) u_id_dispatch (
        .clk,
        .reset_i,
        .in_valid_i(inst_valid_i),
        .in_ready_o(inst_ready_o),
        .in_data_i(decoded),
        .out_valid_o(id_valid),
        .out_ready_i(dispatch_ready),
        .out_data_o(id_q)
    );

    dispatch u_dispatch (
        .id_i(id_q),
        .ex_forward_i(ex_forward),
        .wb_forward_i(wb_forward),
        .rf_port(rf_bus.reader),
        .ex_o(dispatched)
    );

    regfile u_regfile (
        .clk,
        .reset_i,
        .write_i(wb_forward),
        .rd_port(rf_bus.provider)
    );

    pipe_stage #(
        .payload_t(pipeline_pkg::dispatch_ex_t)
    ) u_dispatch_ex (
        .clk,
        .reset_i,
        .in_valid_i(id_valid),
        .in_ready_o(dispatch_ready),
        .in_data_i(dispatched),
        .out_valid_o(ex_valid),
        .out_ready_i(ex_ready),
        .out_data_o(ex_q)
    );

    ex u_ex (
        .clk,
        .reset_i,
        .in_valid_i(ex_valid),
        .in_ready_o(ex_ready),
        .in_data_i(ex_q),
        .div_port(div_bus.client),
        .ex_forward_o(ex_forward),
        .wb_o(wb_forward),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o(commit_pc_o)
    );

    div u_div (
        .clk,
        .reset_i,
        .div_port(div_bus.server)
    );

    assign commit_rd_o = wb_forward.reg_write_addr;
    assign commit_we_o = wb_forward.reg_write_en;
    assign commit_data_o = wb_forward.reg_write_data;

endmodule

`default_nettype wire

/* tests/backend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "backend_macros.svh"

module backend_tb;

    localparam int N_DIRECTED = 52;
    localparam int N_RANDOM = 200;
    localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * 40 + 200;

    typedef struct packed {
        logic [`BACKEND_XLEN-1:0]   pc;
        logic [`BACKEND_REG_AW-1:0] rd;
        logic                       we;
        logic [`BACKEND_XLEN-1:0]   data;
    } commit_t;

    logic                       clk;
    logic                       reset_i;
    logic                       inst_valid_i;
    logic                       inst_ready_o;
    logic [`BACKEND_XLEN-1:0]   inst_i;
    logic [`BACKEND_XLEN-1:0]   pc_i;
    logic                       commit_valid_o;
    logic [`BACKEND_XLEN-1:0]   commit_pc_o;
    logic [`BACKEND_REG_AW-1:0] commit_rd_o;
    logic                       commit_we_o;
    logic [`BACKEND_XLEN-1:0]   commit_data_o;

    logic [`BACKEND_XLEN-1:0]   model_regs [`BACKEND_NREGS];
    commit_t                    exp_q [$];
    logic [`BACKEND_XLEN-1:0]   next_pc;
    logic [31:0]                rng_state;
    string                      cur_test;
    int                         cycles;
    int                         stall_cycles;

    backend backend_inst (
        .clk(clk),
        .reset_i(reset_i),
        .inst_valid_i(inst_valid_i),
        .inst_ready_o(inst_ready_o),
        .inst_i(inst_i),
        .pc_i(pc_i),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o(commit_pc_o),
        .commit_rd_o(commit_rd_o),
        .commit_we_o(commit_we_o),
        .commit_data_o(commit_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail($sformatf("MISMATCH test=%s %s expected=0x%08h actual=0x%08h",
                           cur_test, what, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk);
        return {op, 11'b0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [11:0] imm);
        return {op, 4'b0, imm, rj, rd};
    endfunction

    // reference model, applied in program order when an instruction is sent
    function automatic commit_t model_step(input logic [31:0] inst, input logic [31:0] pc);
        commit_t c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic known;
        a = model_regs[inst[9:5]];
        b = model_regs[inst[14:10]];
        imm = {{20{inst[21]}}, inst[21:10]};
        known = 1'b1;
        c.pc = pc;
        c.rd = inst[4:0];
        c.data = '0;
        case (inst[31:26])
            isa_pkg::OP_ADD:  c.data = a + b;
            isa_pkg::OP_SUB:  c.data = a - b;
            isa_pkg::OP_AND:  c.data = a & b;
            isa_pkg::OP_OR:   c.data = a | b;
            isa_pkg::OP_XOR:  c.data = a ^ b;
            isa_pkg::OP_SLT:  c.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::OP_ADDI: c.data = a + imm;
            isa_pkg::OP_DIVU: c.data = (b == 0) ? 32'hffff_ffff : a / b;
            isa_pkg::OP_MODU: c.data = (b == 0) ? a : a % b;
            default:          known = 1'b0;
        endcase
        c.we = known && (c.rd != 0);
        if (c.we) begin
            model_regs[c.rd] = c.data;
        end
        return c;
    endfunction

    task automatic send(input logic [31:0] inst);
        exp_q.push_back(model_step(inst, next_pc));
        @(negedge clk);
        inst_valid_i = 1'b1;
        inst_i = inst;
        pc_i = next_pc;
        // ready depends only on pipeline state, stable mid-cycle
        while (!inst_ready_o) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_valid_i = 1'b0;
        end
    endtask

    task automatic test_reset();
        cur_test = "reset";
        check("inst_ready_o", 32'd1, inst_ready_o);
        check("commit_valid_o", 32'd0, commit_valid_o);
        for (int k = 0; k < 16; k++) begin
            send(enc_r(isa_pkg::OP_OR, 5'(2 * k), 5'(2 * k), 5'(2 * k + 1)));
        end
        idle(1);
    endtask

    task automatic test_alu();
        cur_test = "alu";
        send(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd0, 12'd123));
        send(enc_i(isa_pkg::OP_ADDI, 5'd2, 5'd0, -12'sd45));
        idle(2);
        send(enc_i(isa_pkg::OP_ADDI, 5'd3, 5'd0, 12'h7ff));
        send(enc_i(isa_pkg::OP_ADDI, 5'd4, 5'd0, 12'h800));
        send(enc_r(isa_pkg::OP_ADD, 5'd5, 5'd1, 5'd2));
        send(enc_r(isa_pkg::OP_SUB, 5'd6, 5'd1, 5'd2));
        send(enc_r(isa_pkg::OP_AND, 5'd7, 5'd3, 5'd2));
        idle(1);
        send(enc_r(isa_pkg::OP_OR, 5'd8, 5'd1, 5'd4));
        send(enc_r(isa_pkg::OP_XOR, 5'd9, 5'd2, 5'd3));
        // signed compares with negative operands
        send(enc_r(isa_pkg::OP_SLT, 5'd10, 5'd2, 5'd1));
        send(enc_r(isa_pkg::OP_SLT, 5'd11, 5'd1, 5'd2));
        send(enc_r(isa_pkg::OP_SLT, 5'd12, 5'd4, 5'd2));
        send(enc_r(isa_pkg::OP_ADD, 5'd0, 5'd1, 5'd1));
        send(enc_r(6'h3f, 5'd13, 5'd1, 5'd2));
        send(enc_r(isa_pkg::OP_ADD, 5'd14, 5'd0, 5'd13));
        idle(1);
    endtask

    task automatic test_forward();
        cur_test = "forward";
        send(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd0, 12'd5));
        send(enc_r(isa_pkg::OP_ADD, 5'd2, 5'd1, 5'd1));
        send(enc_r(isa_pkg::OP_ADD, 5'd3, 5'd1, 5'd2));
        send(enc_r(isa_pkg::OP_ADD, 5'd4, 5'd1, 5'd3));
        send(enc_r(isa_pkg::OP_SUB, 5'd1, 5'd4, 5'd1));
        send(enc_r(isa_pkg::OP_XOR, 5'd5, 5'd1, 5'd4));
        send(enc_i(isa_pkg::OP_ADDI, 5'd6, 5'd1, 12'hfff));
        send(enc_r(isa_pkg::OP_OR, 5'd7, 5'd1, 5'd6));
        // same register written twice, newest must win
        send(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd1, 12'd1));
        send(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd1, 12'd1));
        send(enc_r(isa_pkg::OP_ADD, 5'd8, 5'd1, 5'd1));
        idle(1);
    endtask

    task automatic test_div();
        cur_test = "div";
        stall_cycles = 0;
        send(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd0, 12'd2000));
        send(enc_i(isa_pkg::OP_ADDI, 5'd2, 5'd0, 12'd7));
        send(enc_r(isa_pkg::OP_DIVU, 5'd3, 5'd1, 5'd2));
        send(enc_r(isa_pkg::OP_ADD, 5'd4, 5'd3, 5'd3));
        send(enc_r(isa_pkg::OP_MODU, 5'd5, 5'd1, 5'd2));
        // divisor of zero
        send(enc_r(isa_pkg::OP_DIVU, 5'd6, 5'd1, 5'd0));
        send(enc_r(isa_pkg::OP_MODU, 5'd7, 5'd1, 5'd0));
        send(enc_r(isa_pkg::OP_ADD, 5'd8, 5'd6, 5'd7));
        send(enc_i(isa_pkg::OP_ADDI, 5'd9, 5'd0, -12'sd5));
        send(enc_r(isa_pkg::OP_DIVU, 5'd10, 5'd9, 5'd2));
        idle(1);
        check("inst_ready_o low during division", 32'd1, stall_cycles > 0);
    endtask

    function automatic logic [5:0] pick_opcode(input int sel);
        case (sel)
            0: return isa_pkg::OP_ADD;
            1: return isa_pkg::OP_SUB;
            2: return isa_pkg::OP_AND;
            3: return isa_pkg::OP_OR;
            4: return isa_pkg::OP_XOR;
            5: return isa_pkg::OP_SLT;
            6: return isa_pkg::OP_ADDI;
            7: return isa_pkg::OP_DIVU;
            8: return isa_pkg::OP_MODU;
            default: return 6'h3f;
        endcase
    endfunction

    task automatic test_random();
        logic [5:0]  op;
        logic [31:0] r;
        logic [31:0] gap;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        cur_test = "random";
        for (int i = 0; i < N_RANDOM; i++) begin
            op = pick_opcode(int'(next_rand() % 10));
            rd = 5'(next_rand() % 8);
            rj = 5'(next_rand() % 8);
            rk = 5'(next_rand() % 8);
            r = next_rand();
            if (op == isa_pkg::OP_ADDI) begin
                send(enc_i(op, rd, rj, r[11:0]));
            end else begin
                send(enc_r(op, rd, rj, rk));
            end
            gap = next_rand();
            if (gap % 4 == 0) begin
                idle(int'(gap % 3) + 1);
            end
        end
        idle(1);
    endtask

    // commit outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        commit_t e;
        if (!reset_i && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                fail("a commit arrived while no instruction was outstanding");
            end else begin
                e = exp_q.pop_front();
                check("commit pc", e.pc, commit_pc_o);
                check("commit rd", e.rd, commit_rd_o);
                check("commit we", e.we, commit_we_o);
                if (e.we) begin
                    check("commit data", e.data, commit_data_o);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                fail("timeout: the run went past its cycle limit");
            end
        end
    end

    initial begin
        reset_i = 1'b1;
        inst_valid_i = 1'b0;
        inst_i = '0;
        pc_i = '0;
        next_pc = 32'h0000_1000;
        rng_state = 32'd95;
        stall_cycles = 0;
        cur_test = "reset";
        for (int i = 0; i < `BACKEND_NREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        test_reset();
        test_alu();
        test_forward();
        test_div();
        test_random();
        cur_test = "drain";
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* backend.f */
+incdir+source
source/isa_pkg.sv
source/pipeline_pkg.sv
source/backend_intf.sv
source/decoder.sv
source/pipe_stage.sv
source/regfile.sv
source/dispatch.sv
source/ex.sv
source/div.sv
source/backend.sv
tests/backend_tb.sv

/* Bender.yml */
package:
  name: backend

export_include_dirs:
  - source

sources:
  - source/isa_pkg.sv
  - source/pipeline_pkg.sv
  - source/backend_intf.sv
  - source/decoder.sv
  - source/pipe_stage.sv
  - source/regfile.sv
  - source/dispatch.sv
  - source/ex.sv
  - source/div.sv
  - source/backend.sv
  - target: test
    files:
      - tests/backend_tb.sv
